// File: sim/core_stimulus.txt
// header at 00: program words, data init pairs, events. program at 10, data init at 40 (addr value).
// events at 80: kind (53 store, 4c load), address for a store or register for a load, value.
@00
0000000e 00000003 00000009
@10
00000000 94000033 40000020 44000021
80000030 c0000000 64000022 84000031
a0000032 44000030 84000034 40000100
80000035 c0000000
@40
00000020 11112222
00000021 3333a5a5
00000022 deadbeef
@80
00000053 00000033 00000000
0000004c 00000000 11112222
0000004c 00000001 3333a5a5
00000053 00000030 11112222
00000053 00000031 3333a5a5
0000004c 00000001 11112222
00000053 00000034 11112222
0000004c 00000000 5b5a0100
00000053 00000035 5b5a0100

// File: tb.f
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/pipe_enable_ctrl.sv
source/mem_stage.sv
source/core_mem_top.sv
sim/core_props.sv
sim/tb_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_core
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_core;

	localparam int PROG_AT = 'h10;   // section offsets in the stimulus image.
	localparam int DATA_AT = 'h40;
	localparam int EVT_AT  = 'h80;
	localparam int KIND_S  = 'h53;
	localparam int KIND_L  = 'h4c;

	logic               CLK;
	logic               grst;
	logic               fetch_req;
	core_pkg::addr_t    fetch_addr;
	logic               fetch_ack;
	core_pkg::data_t    fetch_data;
	logic               mem_req;
	logic               mem_we;
	core_pkg::addr_t    mem_addr;
	core_pkg::data_t    mem_wdata;
	logic               mem_ack;
	core_pkg::data_t    mem_rdata;
	logic               load_done;
	core_pkg::reg_idx_t load_reg;
	core_pkg::data_t    load_data;

	core_pkg::data_t stim [0:255];
	core_pkg::data_t dmem [0:(1 << `CORE_ADDR_W) - 1];
	core_pkg::addr_t rd_addrs [$];   // read addresses, in program order.
	int              prog_n;
	int              init_n;
	int              evt_n;
	int              exp_n;
	int              evt_pos;
	int              n_req;
	int              n_ack;
	int              n_fetch;
	int              errs [5];
	bit              started;
	bit              past_end;
	string           names [5] = '{"start-up", "stores", "loads", "annul and stall",
					"single access"};

	core_mem_top dut_i (.*);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	function automatic core_pkg::data_t fill_word(input int a);
		logic [15:0] a16;
		a16 = a[15:0];
		return {a16 ^ 16'h5a5a, a16};
	endfunction

	function automatic core_pkg::data_t prog_word(input core_pkg::addr_t a);
		return (int'(a) < prog_n) ? stim[PROG_AT + int'(a)] : '0;   // NOPs past the end.
	endfunction

	task automatic check_val(input int t, input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errs[t]++;
		end
	endtask

	task automatic take_event(input int t, input int kind, input string a_name,
			input logic [31:0] a, input string v_name, input logic [31:0] v);
		int e;
		e = EVT_AT + 3 * evt_pos;
		assert (evt_pos < evt_n)
		else
		begin
			$display("data event at %0t but the expected event list is used up", $time);
			errs[t]++;
		end
		if (evt_pos < evt_n)
		begin
			check_val(t, "event kind", kind, stim[e]);
			check_val(t, a_name, a, stim[e + 1]);
			check_val(t, v_name, v, stim[e + 2]);
		end
		evt_pos++;
	endtask

	// instruction and data memories with random latency.
	initial
	begin
		int              if_cnt;
		int              dm_cnt;
		core_pkg::data_t if_word;
		core_pkg::data_t dm_word;
		fetch_ack = 1'b0;
		fetch_data = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		if_cnt = 0;
		dm_cnt = 0;
		void'($urandom(90719));
		forever
		begin
			@(posedge CLK);
			fetch_ack <= 1'b0;
			mem_ack <= 1'b0;
			if (fetch_req)
			begin
				if_cnt = $urandom_range(4, 1);
				if_word = prog_word(fetch_addr);
			end
			if (mem_req)
			begin
				dm_cnt = $urandom_range(4, 1);
				if (mem_we)
					dmem[mem_addr] = mem_wdata;   // write lands at the request.
				dm_word = dmem[mem_addr];
			end
			if (if_cnt > 0)
			begin
				if_cnt--;
				if (if_cnt == 0)
				begin
					fetch_ack <= 1'b1;
					fetch_data <= if_word;
				end
			end
			if (dm_cnt > 0)
			begin
				dm_cnt--;
				if (dm_cnt == 0)
				begin
					mem_ack <= 1'b1;
					mem_rdata <= dm_word;
				end
			end
		end
	end

	// port monitor.
	always @(posedge CLK)
	begin
		if (!grst)
		begin
			if (fetch_req)
			begin
				check_val(started ? 3 : 0, "fetch_addr", fetch_addr, n_fetch);
				if (!started)
				begin
					assert (n_req == 0)
					else
					begin
						$display("a data request came before the first fetch");
						errs[0]++;
					end
					$display("test 1 %s: %s", names[0], (errs[0] == 0) ? "ok" : "failed");
				end
				started = 1'b1;
				n_fetch++;
				if (int'(fetch_addr) > prog_n)
					past_end = 1'b1;
			end
			if (mem_req)
			begin
				assert (n_req == n_ack)
				else
				begin
					$display("second data request at %0t while one is outstanding", $time);
					errs[4]++;
				end
				n_req++;
				if (mem_we)
					take_event(1, KIND_S, "mem_addr", mem_addr, "mem_wdata", mem_wdata);
				else if (rd_addrs.size() == 0)
				begin
					assert (0)
					else
					begin
						$display("read at %0t with no load left in the program", $time);
						errs[2]++;
					end
				end
				else
					check_val(2, "mem_addr", mem_addr, rd_addrs.pop_front());
			end
			if (mem_ack)
				n_ack++;
			if (load_done)
				take_event(2, KIND_L, "load_reg", load_reg, "load_data", load_data);
		end
	end

	initial
	begin
		core_pkg::data_t w;
		int              i;
		int              bad;
		int              fails;
		grst = 1'b1;
		$readmemh("sim/core_stimulus.txt", stim);
		prog_n = stim[0];
		init_n = stim[1];
		evt_n = stim[2];
		for (i = 0; i < (1 << `CORE_ADDR_W); i++)
			dmem[i] = fill_word(i);
		for (i = 0; i < init_n; i++)
			dmem[stim[DATA_AT + 2 * i][`CORE_ADDR_W-1:0]] = stim[DATA_AT + 2 * i + 1];
		// expected accesses straight from the instruction fields.
		for (i = 0; i < prog_n; i++)
		begin
			w = stim[PROG_AT + i];
			if (!w[`CORE_SKIP_BIT] &&
			    w[`CORE_CLS_HI:`CORE_CLS_LO] == core_pkg::CLS_LOAD)
				rd_addrs.push_back(w[`CORE_ADDR_HI:0]);
			if (!w[`CORE_SKIP_BIT] &&
			    (w[`CORE_CLS_HI:`CORE_CLS_LO] == core_pkg::CLS_LOAD ||
			     w[`CORE_CLS_HI:`CORE_CLS_LO] == core_pkg::CLS_STORE))
				exp_n++;
		end
		check_val(4, "expected event count", evt_n, exp_n);
		repeat (8) @(posedge CLK);
		grst <= 1'b0;

		while (!(past_end && n_req == n_ack))
			@(posedge CLK);
		repeat (3) @(posedge CLK);   // lets the last load retire.
		check_val(4, "mem_ack count", n_ack, n_req);
		check_val(4, "data event count", evt_pos, evt_n);
		assert (rd_addrs.size() == 0)
		else
		begin
			$display("%0d program loads never read memory", rd_addrs.size());
			errs[2]++;
		end

		bad = 0;
		fails = 0;
		for (i = 0; i < 5; i++)
		begin
			if (i > 0)
				$display("test %0d %s: %s", i + 1, names[i], (errs[i] == 0) ? "ok" : "failed");
			if (errs[i] != 0)
				bad++;
			fails += errs[i];
		end
		$display("%0d tests, %0d passed, %0d failed, %0d failed checks", 5, 5 - bad, bad, fails);
		if (fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog.
	initial
	begin
		#1;
		repeat (60 * prog_n + 8) @(posedge CLK);
		$display("timeout: the program did not run to its end in %0d cycles", 60 * prog_n + 8);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/core_props.sv
`timescale 1ns/1ps
`default_nettype none

module core_props (
	input logic                 CLK,
	input logic                 grst,
	input logic                 fetch_req,
	input logic                 mem_req,
	input logic                 load_done,
	input logic                 icache_busy,
	input logic                 dcache_busy,
	input core_pkg::ctrl_mode_e mode
);

	logic past_valid;

	initial past_valid = 1'b0;

	always @(posedge CLK)
		past_valid <= 1'b1;

	// a new data command only once the last one was acked.
	data_single: assert property (@(posedge CLK) past_valid && mem_req |-> !$past(dcache_busy))
		else $error("mem_req while the data port was still busy");

	fetch_single: assert property (@(posedge CLK) past_valid && fetch_req |-> !$past(icache_busy))
		else $error("fetch_req while the instruction port was still busy");

	// data commands only leave from the memop mode.
	memop_only: assert property (@(posedge CLK)
			past_valid && mem_req |-> $past(mode) == core_pkg::MODE_MEMOP)
		else $error("mem_req without a preceding memop cycle");

	// ports stay quiet in reset.
	reset_quiet: assert property (@(posedge CLK)
			past_valid && grst |-> !fetch_req && !mem_req && !load_done)
		else $error("port strobe during grst");

endmodule

bind core_mem_top core_props props_i (
	.CLK(CLK),
	.grst(grst),
	.fetch_req(fetch_req),
	.mem_req(mem_req),
	.load_done(load_done),
	.icache_busy(icache_busy),
	.dcache_busy(dcache_busy),
	.mode(mode)
);

`default_nettype wire

// File: source/core_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_top (
	input  logic               CLK,
	input  logic               grst,
	output logic               fetch_req,
	output core_pkg::addr_t    fetch_addr,
	input  logic               fetch_ack,
	input  core_pkg::data_t    fetch_data,
	output logic               mem_req,
	output logic               mem_we,
	output core_pkg::addr_t    mem_addr,
	output core_pkg::data_t    mem_wdata,
	input  logic               mem_ack,
	input  core_pkg::data_t    mem_rdata,
	output logic               load_done,
	output core_pkg::reg_idx_t load_reg,
	output core_pkg::data_t    load_data
);

	logic                 cpu_enable;
	logic                 icache_enable;
	logic                 dcache_enable;
	logic                 icache_busy;
	logic                 dcache_busy;
	logic                 d_mem_op;
	logic                 d_load;
	logic                 d_skip;
	logic                 d_stall;
	core_pkg::instr_cls_e d_cls;
	core_pkg::reg_idx_t   d_reg;
	core_pkg::addr_t      d_addr;
	core_pkg::ctrl_mode_e mode;   // visible for the bound checks.

	fetch_unit fetch_i (
		.CLK(CLK), .grst(grst),
		.icache_enable(icache_enable), .cpu_enable(cpu_enable),
		.fetch_ack(fetch_ack), .fetch_data(fetch_data),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .icache_busy(icache_busy),
		.d_mem_op(d_mem_op), .d_load(d_load), .d_skip(d_skip), .d_stall(d_stall),
		.d_cls(d_cls), .d_reg(d_reg), .d_addr(d_addr)
	);

	pipe_enable_ctrl ctrl_i (
		.CLK(CLK), .grst(grst),
		.icache_busy(icache_busy), .dcache_busy(dcache_busy),
		.d_mem_op(d_mem_op), .d_load(d_load), .d_skip(d_skip), .d_stall(d_stall),
		.mode(mode), .cpu_enable(cpu_enable),
		.icache_enable(icache_enable), .dcache_enable(dcache_enable)
	);

	mem_stage mem_i (
		.CLK(CLK), .grst(grst),
		.cpu_enable(cpu_enable), .dcache_enable(dcache_enable),
		.d_cls(d_cls), .d_skip(d_skip), .d_reg(d_reg), .d_addr(d_addr),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.dcache_busy(dcache_busy),
		.load_done(load_done), .load_reg(load_reg), .load_data(load_data)
	);

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module mem_stage (
	input  logic                 CLK,
	input  logic                 grst,
	input  logic                 cpu_enable,
	input  logic                 dcache_enable,
	input  core_pkg::instr_cls_e d_cls,
	input  logic                 d_skip,
	input  core_pkg::reg_idx_t   d_reg,
	input  core_pkg::addr_t      d_addr,
	input  logic                 mem_ack,
	input  core_pkg::data_t      mem_rdata,
	output logic                 mem_req,
	output logic                 mem_we,
	output core_pkg::addr_t      mem_addr,
	output core_pkg::data_t      mem_wdata,
	output logic                 dcache_busy,
	output logic                 load_done,
	output core_pkg::reg_idx_t   load_reg,
	output core_pkg::data_t      load_data
);

	core_pkg::instr_cls_e x_cls;
	core_pkg::reg_idx_t   x_reg;
	core_pkg::addr_t      x_addr;
	core_pkg::data_t      regs [`CORE_REG_N];
	logic                 rd_ack;

	// only one command is out, so mem_we still tells what is being acked.
	assign rd_ack = mem_ack && !mem_we;

	// execute register.
	always_ff @(posedge CLK)
	begin
		if (grst)
			x_cls <= core_pkg::CLS_NOP;
		else if (cpu_enable)
			x_cls <= d_skip ? core_pkg::CLS_NOP : d_cls;   // annulled slot.
	end

	always_ff @(posedge CLK)
	begin
		if (cpu_enable)
		begin
			x_reg <= d_reg;
			x_addr <= d_addr;
		end
	end

	// data port control.
	always_ff @(posedge CLK)
	begin
		if (grst)
		begin
			mem_req <= 1'b0;
			dcache_busy <= 1'b0;
			load_done <= 1'b0;
		end
		else
		begin
			mem_req <= dcache_enable;
			if (dcache_enable)
				dcache_busy <= 1'b1;
			else if (mem_ack)
				dcache_busy <= 1'b0;
			load_done <= rd_ack;
		end
	end

	// request payload with the store data read from the register file.
	always_ff @(posedge CLK)
	begin
		if (dcache_enable)
		begin
			mem_we <= (x_cls == core_pkg::CLS_STORE);
			mem_addr <= x_addr;
			mem_wdata <= regs[x_reg];
		end
	end

	// register file, written by load data only.
	always_ff @(posedge CLK)
	begin
		if (grst)
		begin
			for (int i = 0; i < `CORE_REG_N; i++)
				regs[i] <= '0;
		end
		else if (rd_ack)
			regs[x_reg] <= mem_rdata;
	end

	// retire payload for load_done.
	always_ff @(posedge CLK)
	begin
		if (rd_ack)
		begin
			load_reg <= x_reg;   // x_reg is held until the load retires.
			load_data <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/pipe_enable_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_enable_ctrl (
	input  logic                 CLK,
	input  logic                 grst,
	input  logic                 icache_busy,
	input  logic                 dcache_busy,
	input  logic                 d_mem_op,
	input  logic                 d_load,
	input  logic                 d_skip,
	input  logic                 d_stall,
	output core_pkg::ctrl_mode_e mode,
	output logic                 cpu_enable,
	output logic                 icache_enable,
	output logic                 dcache_enable
);

	logic grst_dly;
	logic starter;        // single kick after reset.
	logic just_issued;    // data command went out last cycle.
	logic ld_issue_reg;
	logic ld_issue_dly;
	logic x_load;
	logic x_mem_op;
	logic normal;
	logic ports_idle;
	logic enter_memop;
	logic exit_memop;
	logic ld_enable;

	assign normal     = (mode == core_pkg::MODE_NORMAL);
	assign ports_idle = !icache_busy && !dcache_busy;

	// held off until the starter pulse has gone out.
	assign cpu_enable = starter || (normal && !icache_busy && !grst_dly);

	assign enter_memop = normal && cpu_enable && (d_mem_op || d_stall) && !d_skip;

	// a load may leave only once its read has come back.
	assign exit_memop = !normal && ports_idle &&
			    (x_load ? ld_issue_dly : !just_issued);

	assign ld_enable = !normal && !ld_issue_reg && !dcache_busy && !just_issued;

	assign icache_enable = starter ||
			       (normal ? (cpu_enable && !enter_memop) : exit_memop);

	assign dcache_enable = x_load ? ld_enable : (exit_memop && x_mem_op);

	always_ff @(posedge CLK)
	begin
		if (grst)
		begin
			grst_dly <= 1'b1;
			starter <= 1'b0;
			mode <= core_pkg::MODE_NORMAL;
			just_issued <= 1'b0;
			ld_issue_reg <= 1'b0;
			ld_issue_dly <= 1'b0;
			x_load <= 1'b0;
			x_mem_op <= 1'b0;
		end
		else
		begin
			grst_dly <= 1'b0;
			starter <= grst_dly;
			just_issued <= dcache_enable;   // keeps a single command outstanding.

			if (cpu_enable)
			begin
				x_load <= d_load && !d_skip;
				x_mem_op <= d_mem_op && !d_skip;
			end

			if (normal)
			begin
				if (enter_memop)
					mode <= core_pkg::MODE_MEMOP;
			end
			else if (exit_memop)
			begin
				mode <= core_pkg::MODE_NORMAL;
				ld_issue_reg <= 1'b0;
				ld_issue_dly <= 1'b0;
			end
			else
			begin
				if (ld_enable)
					ld_issue_reg <= 1'b1;
				ld_issue_dly <= ld_issue_reg;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_unit (
	input  logic                 CLK,
	input  logic                 grst,
	input  logic                 icache_enable,
	input  logic                 cpu_enable,
	input  logic                 fetch_ack,
	input  core_pkg::data_t      fetch_data,
	output logic                 fetch_req,
	output core_pkg::addr_t      fetch_addr,
	output logic                 icache_busy,
	output logic                 d_mem_op,
	output logic                 d_load,
	output logic                 d_skip,
	output logic                 d_stall,
	output core_pkg::instr_cls_e d_cls,
	output core_pkg::reg_idx_t   d_reg,
	output core_pkg::addr_t      d_addr
);

	core_pkg::addr_t pc;
	core_pkg::data_t d_word;       // decode register.
	logic            word_taken;   // decode word moved on to execute.

	// control side of the instruction port.
	always_ff @(posedge CLK)
	begin
		if (grst)
		begin
			pc <= '0;
			fetch_req <= 1'b0;
			icache_busy <= 1'b0;
			d_word <= '0;   // all zero decodes as a NOP.
			word_taken <= 1'b0;
		end
		else
		begin
			fetch_req <= icache_enable;
			if (icache_enable)
				pc <= pc + 1'b1;

			if (icache_enable)
				icache_busy <= 1'b1;
			else if (fetch_ack)
				icache_busy <= 1'b0;

			if (fetch_ack)
			begin
				d_word <= fetch_data;
				word_taken <= 1'b0;
			end
			else if (cpu_enable)
				word_taken <= 1'b1;
		end
	end

	// address of the fetch in flight.
	always_ff @(posedge CLK)
	begin
		if (icache_enable)
			fetch_addr <= pc;
	end

	// field split.
	assign d_cls  = core_pkg::instr_cls_e'(d_word[`CORE_CLS_HI:`CORE_CLS_LO]);
	assign d_reg  = d_word[`CORE_REG_HI:`CORE_REG_LO];
	assign d_addr = d_word[`CORE_ADDR_HI:0];

	// a word that already went to execute is not decoded a second time.
	assign d_skip = d_word[`CORE_SKIP_BIT] || word_taken;

	// control flags from the class.
	always_comb
	begin
		d_load   = 1'b0;
		d_mem_op = 1'b0;
		d_stall  = 1'b0;
		case (d_cls)
			core_pkg::CLS_LOAD:
			begin
				d_load   = 1'b1;
				d_mem_op = 1'b1;
			end
			core_pkg::CLS_STORE:
				d_mem_op = 1'b1;
			core_pkg::CLS_STALL:
				d_stall = 1'b1;
			default:
				d_mem_op = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

	typedef logic [`CORE_ADDR_W-1:0] addr_t;     // word address.
	typedef logic [`CORE_DATA_W-1:0] data_t;     // data or instruction word.
	typedef logic [`CORE_REG_W-1:0]  reg_idx_t;

	// instruction class taken straight from the top two bits.
	typedef enum logic [1:0] {
		CLS_NOP   = 2'b00,
		CLS_LOAD  = 2'b01,
		CLS_STORE = 2'b10,
		CLS_STALL = 2'b11
	} instr_cls_e;

	// memop holds the pipeline while a data access or stall runs.
	typedef enum logic {
		MODE_MEMOP  = 1'b0,
		MODE_NORMAL = 1'b1
	} ctrl_mode_e;

endpackage

`default_nettype wire

// File: source/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// widths.
`define CORE_ADDR_W 16
`define CORE_DATA_W 32

// register file.
`define CORE_REG_N 8
`define CORE_REG_W 3

// instruction word fields.
`define CORE_CLS_HI   31
`define CORE_CLS_LO   30
`define CORE_SKIP_BIT 29   // annulled slot.
`define CORE_REG_HI   28
`define CORE_REG_LO   26
`define CORE_ADDR_HI  15   // data address sits in the low bits.

`endif
